/* include/ncpu_tsc_config.svh */
`ifndef NCPU_TSC_CONFIG_SVH
`define NCPU_TSC_CONFIG_SVH

// MSR data path width
`define NCPU_DW 32

// Compare field width, also the number of low TSR bits compared
`define NCPU_TSC_CNT_DW 24

// TCR control bits, above the compare field
`define NCPU_MSR_TSC_TCR_EN 24
`define NCPU_MSR_TSC_TCR_I 25
`define NCPU_MSR_TSC_TCR_P 26
`define NCPU_MSR_TSC_TCR_RB1 27

// MSR address space
`define NCPU_MSR_ADDR_DW 2
`define NCPU_MSR_TSR 2'd0
`define NCPU_MSR_TCR 2'd1
`define NCPU_MSR_IMR 2'd2
`define NCPU_MSR_IRR 2'd3

// External interrupt lines
`define NCPU_EXT_IRQ_NUM 3

// IMR/IRR width, bit 0 is the timer
`define NCPU_IRQ_DW (`NCPU_EXT_IRQ_NUM + 1)

`endif

/* hw/tsc_pkg.sv */
`include "ncpu_tsc_config.svh"

package tsc_pkg;

   // TCR layout, MSB first
   // Reserved bits sit above RB1 and read as zero
   typedef struct packed {
      logic [`NCPU_DW-`NCPU_MSR_TSC_TCR_RB1-2:0] reserved;
      // Spare bit, kept as written
      logic                                     rb1;
      // Pending, live timer interrupt on read
      logic                                     p;
      // Interrupt enable
      logic                                     i;
      // Count enable
      logic                                     en;
      // Compare value
      logic [`NCPU_TSC_CNT_DW-1:0]              cnt;
   } tcr_fields_t;

   // Same TCR word, raw or by field
   typedef union packed {
      logic [`NCPU_DW-1:0] raw;
      tcr_fields_t         f;
   } tcr_u;

   // MSR addresses
   typedef enum logic [`NCPU_MSR_ADDR_DW-1:0] {
      MSR_TSR = `NCPU_MSR_TSR,
      MSR_TCR = `NCPU_MSR_TCR,
      MSR_IMR = `NCPU_MSR_IMR,
      MSR_IRR = `NCPU_MSR_IRR
   } msr_addr_e;

endpackage

/* hw/msr_bus_slave.sv */
`timescale 1ns/1ns

`include "ncpu_tsc_config.svh"

module msr_bus_slave
   import tsc_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   // Host port
   input  logic                    msr_req,
   input  logic                    msr_we,
   input  msr_addr_e               msr_addr,
   input  logic [`NCPU_DW-1:0]     msr_wdata,
   output logic                    msr_ack,
   output logic [`NCPU_DW-1:0]     msr_rdata,
   // Current register values
   input  logic [`NCPU_DW-1:0]     tsr,
   input  logic [`NCPU_DW-1:0]     tcr_rd,
   input  logic [`NCPU_IRQ_DW-1:0] imr,
   input  logic [`NCPU_IRQ_DW-1:0] irr,
   // Write side to the blocks
   output logic [`NCPU_DW-1:0]     wr_data,
   output logic                    tsr_we,
   output logic                    tcr_we,
   output logic                    imr_we
);

   logic               accept;
   logic               wr_acc;
   logic               ack_nxt;
   logic [`NCPU_DW-1:0] rd_mux;

   // New transaction: request up, previous ack already dropped
   assign accept = msr_req & ~msr_ack;
   assign wr_acc = accept & msr_we;

   // One strobe per write, IRR has none
   assign tsr_we = wr_acc & (msr_addr == MSR_TSR);
   assign tcr_we = wr_acc & (msr_addr == MSR_TCR);
   assign imr_we = wr_acc & (msr_addr == MSR_IMR);

   // Shared write data bus
   assign wr_data = msr_wdata;

   // Read mux
   always_comb begin
      rd_mux = '0;
      case (msr_addr)
         MSR_TSR: rd_mux = tsr;
         // Already bypassed by the timer
         MSR_TCR: rd_mux = tcr_rd;
         MSR_IMR: rd_mux = {{(`NCPU_DW-`NCPU_IRQ_DW){1'b0}}, imr};
         MSR_IRR: rd_mux = {{(`NCPU_DW-`NCPU_IRQ_DW){1'b0}}, irr};
         default: rd_mux = '0;
      endcase
   end

   // Handshake
   // Rise one cycle after req, hold while req stays, drop one cycle after req falls
   always_comb begin
      if (accept) begin
         ack_nxt = 1'b1;
      end else if (msr_ack && !msr_req) begin
         ack_nxt = 1'b0;
      end else begin
         ack_nxt = msr_ack;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         msr_ack <= 1'b0;
      end else begin
         msr_ack <= ack_nxt;
      end
   end

   // Read data captured at the accepting edge, stable while ack is high
   always_ff @(posedge clk) begin
      if (accept) begin
         msr_rdata <= rd_mux;
      end
   end

   // Ack only ever answers a request
   a_ack_needs_req: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(msr_ack) |-> $past(msr_req)
   );

   // Blocks never see two writes at once
   a_one_strobe: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0({tsr_we, tcr_we, imr_we})
   );

endmodule

/* hw/tsc_timer.sv */
`timescale 1ns/1ns

`include "ncpu_tsc_config.svh"

module tsc_timer
   import tsc_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic [`NCPU_DW-1:0] wr_data,
   input  logic                tsr_we,
   input  logic                tcr_we,
   output logic [`NCPU_DW-1:0] tsr,
   output logic [`NCPU_DW-1:0] tcr_rd,
   output logic                tsc_irq
);

   tcr_u tcr_q;
   tcr_u tcr_in;
   tcr_u tcr_ff;
   tcr_u tcr_view;
   logic irq_set;
   logic irq_clr;

   // Incoming TCR word, reserved bits forced to zero
   always_comb begin
      tcr_in = tcr_u'(wr_data);
      tcr_in.f.reserved = '0;
   end

   // Stored TCR
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tcr_q <= '0;
      end else if (tcr_we) begin
         tcr_q <= tcr_in;
      end
   end

   // Stored view, P shows the live interrupt
   always_comb begin
      tcr_ff = tcr_q;
      tcr_ff.f.p = tsc_irq;
   end

   // Same-cycle write wins on read and on control
   assign tcr_view = tcr_we ? tcr_in : tcr_ff;
   assign tcr_rd = tcr_view.raw;

   // TSR counter
   // Write has priority over counting
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tsr <= '0;
      end else if (tsr_we) begin
         tsr <= wr_data;
      end else if (tcr_view.f.en) begin
         tsr <= tsr + 1'b1;
      end
   end

   // Low counter bits hit the compare value with interrupt enabled
   assign irq_set = (tsr[`NCPU_TSC_CNT_DW-1:0] == tcr_view.f.cnt) & tcr_view.f.i;

   // Software writes P as zero
   assign irq_clr = tcr_we & ~tcr_in.f.p;

   // Pending flag, clear beats set
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tsc_irq <= 1'b0;
      end else if (irq_set | irq_clr) begin
         tsc_irq <= irq_set & ~irq_clr;
      end
   end

   // No new interrupt without I in force the cycle before
   a_irq_needs_i: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(tsc_irq) |-> $past(tcr_view.f.i)
   );

endmodule

/* hw/epu_irq_ctrl.sv */
`timescale 1ns/1ns

`include "ncpu_tsc_config.svh"

module epu_irq_ctrl (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [`NCPU_EXT_IRQ_NUM-1:0] ext_irq,
   input  logic                         tsc_irq,
   input  logic [`NCPU_DW-1:0]          wr_data,
   input  logic                         imr_we,
   output logic [`NCPU_IRQ_DW-1:0]      imr,
   output logic [`NCPU_IRQ_DW-1:0]      irr,
   output logic                         irq
);

   logic [`NCPU_EXT_IRQ_NUM-1:0] ext_s1;
   logic [`NCPU_EXT_IRQ_NUM-1:0] ext_s2;
   logic [`NCPU_IRQ_DW-1:0]      pend;

   // Two-flop synchronizer for the external lines
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ext_s1 <= '0;
         ext_s2 <= '0;
      end else begin
         ext_s1 <= ext_irq;
         ext_s2 <= ext_s1;
      end
   end

   // Mask register, low bits of the write word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         imr <= '0;
      end else if (imr_we) begin
         imr <= wr_data[`NCPU_IRQ_DW-1:0];
      end
   end

   // Raw requests
   // Bit 0 is the timer, external lines above it
   assign irr = {ext_s2, tsc_irq};

   // Enabled requests
   assign pend = irr & imr;

   // Single interrupt line to the core
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         irq <= 1'b0;
      end else begin
         irq <= |pend;
      end
   end

   // Fully masked means quiet on the next cycle
   a_masked_quiet: assert property (
      @(posedge clk) disable iff (!rst_n)
      ($past(imr) == '0) |-> !irq
   );

endmodule

/* hw/epu_tsc_top.sv */
`timescale 1ns/1ns

`include "ncpu_tsc_config.svh"

module epu_tsc_top
   import tsc_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst_n,
   // MSR host port
   input  logic                         msr_req,
   input  logic                         msr_we,
   input  msr_addr_e                    msr_addr,
   input  logic [`NCPU_DW-1:0]          msr_wdata,
   output logic                         msr_ack,
   output logic [`NCPU_DW-1:0]          msr_rdata,
   // Interrupt lines
   input  logic [`NCPU_EXT_IRQ_NUM-1:0] ext_irq,
   output logic                         irq
);

   logic [`NCPU_DW-1:0]     wr_data;
   logic                    tsr_we;
   logic                    tcr_we;
   logic                    imr_we;
   logic [`NCPU_DW-1:0]     tsr;
   logic [`NCPU_DW-1:0]     tcr_rd;
   logic [`NCPU_IRQ_DW-1:0] imr;
   logic [`NCPU_IRQ_DW-1:0] irr;
   logic                    tsc_irq;

   // Host side, decode and read mux
   msr_bus_slave u_slave (
      .clk       (clk),
      .rst_n     (rst_n),
      .msr_req   (msr_req),
      .msr_we    (msr_we),
      .msr_addr  (msr_addr),
      .msr_wdata (msr_wdata),
      .msr_ack   (msr_ack),
      .msr_rdata (msr_rdata),
      .tsr       (tsr),
      .tcr_rd    (tcr_rd),
      .imr       (imr),
      .irr       (irr),
      .wr_data   (wr_data),
      .tsr_we    (tsr_we),
      .tcr_we    (tcr_we),
      .imr_we    (imr_we)
   );

   // Timestamp counter and compare
   tsc_timer u_timer (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_data (wr_data),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .tsr     (tsr),
      .tcr_rd  (tcr_rd),
      .tsc_irq (tsc_irq)
   );

   // Interrupt combine and mask
   epu_irq_ctrl u_irq (
      .clk     (clk),
      .rst_n   (rst_n),
      .ext_irq (ext_irq),
      .tsc_irq (tsc_irq),
      .wr_data (wr_data),
      .imr_we  (imr_we),
      .imr     (imr),
      .irr     (irr),
      .irq     (irq)
   );

endmodule

/* testbench/tb_epu_tsc.sv */
`timescale 1ns/1ns

`include "ncpu_tsc_config.svh"

module tb_epu_tsc
   import tsc_pkg::*;
();

   // Table length and run limit
   localparam int unsigned TBL_LEN = 37;
   localparam int unsigned WATCHDOG_NS = TBL_LEN * 250 * 100;

   // Table operations
   typedef enum {OP_WRITE, OP_READ, OP_READ_MIN, OP_WAIT_IRQ, OP_HOLD_IRQ, OP_SET_EXT} tb_op_e;

   logic                         clk = 1'b0;
   logic                         rst_n;
   logic                         msr_req;
   logic                         msr_we;
   msr_addr_e                    msr_addr;
   logic [`NCPU_DW-1:0]          msr_wdata;
   logic                         msr_ack;
   logic [`NCPU_DW-1:0]          msr_rdata;
   logic [`NCPU_EXT_IRQ_NUM-1:0] ext_irq;
   logic                         irq;

   // Stimulus table
   tb_op_e              tbl_op   [TBL_LEN];
   msr_addr_e           tbl_addr [TBL_LEN];
   logic [`NCPU_DW-1:0] tbl_data [TBL_LEN];
   logic [`NCPU_DW-1:0] tbl_exp  [TBL_LEN];
   logic [`NCPU_DW-1:0] tbl_mask [TBL_LEN];
   int unsigned         tbl_cnt = 0;

   int unsigned mismatch_cnt = 0;
   int unsigned proto_cnt = 0;
   int unsigned timeout_cnt = 0;

   epu_tsc_top dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .msr_req   (msr_req),
      .msr_we    (msr_we),
      .msr_addr  (msr_addr),
      .msr_wdata (msr_wdata),
      .msr_ack   (msr_ack),
      .msr_rdata (msr_rdata),
      .ext_irq   (ext_irq),
      .irq       (irq)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   function automatic string reg_name(input msr_addr_e addr);
      case (addr)
         MSR_TSR: return "TSR";
         MSR_TCR: return "TCR";
         MSR_IMR: return "IMR";
         default: return "IRR";
      endcase
   endfunction

   // TCR word from its fields
   function automatic logic [`NCPU_DW-1:0] make_tcr(
      input logic [`NCPU_DW-`NCPU_MSR_TSC_TCR_RB1-2:0] rsv,
      input logic rb1,
      input logic p,
      input logic i,
      input logic en,
      input logic [`NCPU_TSC_CNT_DW-1:0] cnt
   );
      tcr_u w;
      w.f.reserved = rsv;
      w.f.rb1 = rb1;
      w.f.p = p;
      w.f.i = i;
      w.f.en = en;
      w.f.cnt = cnt;
      return w.raw;
   endfunction

   task automatic add_entry(input tb_op_e op, input msr_addr_e addr,
                            input logic [`NCPU_DW-1:0] data,
                            input logic [`NCPU_DW-1:0] exp,
                            input logic [`NCPU_DW-1:0] mask);
      if (tbl_cnt < TBL_LEN) begin
         tbl_op[tbl_cnt] = op;
         tbl_addr[tbl_cnt] = addr;
         tbl_data[tbl_cnt] = data;
         tbl_exp[tbl_cnt] = exp;
         tbl_mask[tbl_cnt] = mask;
      end
      tbl_cnt++;
   endtask

   // Random values first and table entries derived from them
   task automatic build_table();
      logic [`NCPU_DW-1:0]          t_val;
      logic [`NCPU_DW-1:0]          v_tsr;
      logic [`NCPU_TSC_CNT_DW-1:0]  cnt_a;
      logic [`NCPU_TSC_CNT_DW-1:0]  cmp;
      logic [`NCPU_TSC_CNT_DW-1:0]  far;
      logic [`NCPU_TSC_CNT_DW-1:0]  c_val;
      logic [7:0]                   tsr_hi;
      logic [`NCPU_EXT_IRQ_NUM-1:0] ext_bits;
      logic [`NCPU_DW-1:0]          ext_irr;
      logic [`NCPU_DW-1:0]          all;
      t_val = $urandom();
      // Bit 23 clear so that V plus 20 does not wrap in the low bits
      v_tsr = $urandom() & 32'hFF7F_FFFF;
      cnt_a = $urandom();
      cmp = v_tsr[`NCPU_TSC_CNT_DW-1:0] + 24'd20;
      far = cmp ^ 24'h800000;
      c_val = $urandom() | 24'h000100;
      tsr_hi = $urandom();
      ext_bits = 3'b001 << ($urandom() % `NCPU_EXT_IRQ_NUM);
      ext_irr = 32'(ext_bits) << 1;
      all = '1;
      // Reset values
      add_entry(OP_READ, MSR_TSR, '0, '0, all);
      add_entry(OP_READ, MSR_TCR, '0, '0, all);
      add_entry(OP_READ, MSR_IMR, '0, '0, all);
      add_entry(OP_READ, MSR_IRR, '0, '0, all);
      add_entry(OP_HOLD_IRQ, MSR_TSR, 32'd5, 32'd0, '0);
      // Stopped counter with reserved bits dropped and P showing the idle timer
      add_entry(OP_WRITE, MSR_TSR, t_val, '0, '0);
      add_entry(OP_READ, MSR_TSR, '0, t_val, all);
      add_entry(OP_WRITE, MSR_TCR, make_tcr(4'hF, 1'b1, 1'b1, 1'b0, 1'b0, cnt_a), '0, '0);
      add_entry(OP_READ, MSR_TCR, '0, make_tcr(4'h0, 1'b1, 1'b0, 1'b0, 1'b0, cnt_a), all);
      // Compare hit with I set and P written as zero
      add_entry(OP_WRITE, MSR_IMR, 32'd1, '0, '0);
      add_entry(OP_WRITE, MSR_TSR, v_tsr, '0, '0);
      add_entry(OP_WRITE, MSR_TCR, make_tcr(4'h0, 1'b0, 1'b0, 1'b1, 1'b1, cmp), '0, '0);
      add_entry(OP_WAIT_IRQ, MSR_TSR, 32'd200, 32'd1, '0);
      add_entry(OP_READ_MIN, MSR_TSR, '0, 32'(cmp), 32'h00FF_FFFF);
      add_entry(OP_READ, MSR_TCR, '0, make_tcr(4'h0, 1'b0, 1'b1, 1'b1, 1'b1, cmp), all);
      add_entry(OP_READ, MSR_IRR, '0, 32'd1, 32'd1);
      // Clear by P written as zero and the compare moved away
      add_entry(OP_WRITE, MSR_TCR, make_tcr(4'h0, 1'b0, 1'b0, 1'b1, 1'b1, far), '0, '0);
      add_entry(OP_WAIT_IRQ, MSR_TSR, 32'd5, 32'd0, '0);
      add_entry(OP_READ, MSR_TCR, '0, make_tcr(4'h0, 1'b0, 1'b0, 1'b1, 1'b1, far), all);
      add_entry(OP_READ, MSR_IRR, '0, 32'd0, 32'd1);
      // Counter runs through the compare with I clear
      add_entry(OP_WRITE, MSR_TCR, make_tcr(4'h0, 1'b0, 1'b0, 1'b0, 1'b1, c_val), '0, '0);
      add_entry(OP_WRITE, MSR_TSR, {tsr_hi, c_val - 24'd30}, '0, '0);
      add_entry(OP_HOLD_IRQ, MSR_TSR, 32'd100, 32'd0, '0);
      add_entry(OP_READ, MSR_TCR, '0, make_tcr(4'h0, 1'b0, 1'b0, 1'b0, 1'b1, c_val), all);
      add_entry(OP_READ, MSR_IRR, '0, 32'd0, 32'd1);
      // External line masked and then unmasked
      add_entry(OP_WRITE, MSR_IMR, 32'd0, '0, '0);
      add_entry(OP_SET_EXT, MSR_TSR, 32'(ext_bits), '0, '0);
      add_entry(OP_HOLD_IRQ, MSR_TSR, 32'd4, 32'd0, '0);
      add_entry(OP_READ, MSR_IRR, '0, ext_irr, all);
      // IRR is read only
      add_entry(OP_WRITE, MSR_IRR, 32'd0, '0, '0);
      add_entry(OP_READ, MSR_IRR, '0, ext_irr, all);
      add_entry(OP_WRITE, MSR_IMR, ext_irr, '0, '0);
      add_entry(OP_WAIT_IRQ, MSR_TSR, 32'd200, 32'd1, '0);
      add_entry(OP_READ, MSR_IMR, '0, ext_irr, all);
      add_entry(OP_SET_EXT, MSR_TSR, 32'd0, '0, '0);
      add_entry(OP_WAIT_IRQ, MSR_TSR, 32'd5, 32'd0, '0);
      add_entry(OP_READ, MSR_IRR, '0, 32'd0, all);
   endtask

   // One four-phase MSR transaction
   task automatic msr_access(input logic we, input msr_addr_e addr,
                             input logic [`NCPU_DW-1:0] wdata,
                             output logic [`NCPU_DW-1:0] rdata);
      @(negedge clk);
      msr_req = 1'b1;
      msr_we = we;
      msr_addr = addr;
      msr_wdata = wdata;
      @(negedge clk);
      if (msr_ack !== 1'b1) begin
         $display("Handshake fault at %0t: msr_ack not high one cycle after msr_req rose",
                  $time);
         proto_cnt++;
      end
      rdata = msr_rdata;
      msr_req = 1'b0;
      msr_we = 1'b0;
      @(negedge clk);
      if (msr_ack !== 1'b0) begin
         $display("Handshake fault at %0t: msr_ack not low one cycle after msr_req fell",
                  $time);
         proto_cnt++;
      end
   endtask

   // Bounded wait for an irq level
   task automatic wait_irq(input logic level, input int unsigned bound);
      int unsigned n;
      bit          seen;
      n = 0;
      seen = 1'b0;
      while (!seen && n < bound) begin
         @(negedge clk);
         n++;
         if (irq === level) begin
            seen = 1'b1;
         end
      end
      if (!seen) begin
         $display("Timeout at %0t: irq did not reach %0d within %0d cycles",
                  $time, level, bound);
         timeout_cnt++;
      end
   endtask

   // irq must keep one level for a number of cycles
   task automatic hold_irq(input logic level, input int unsigned cycles);
      repeat (cycles) begin
         @(negedge clk);
         if (irq !== level) begin
            $display("MISMATCH time=%0t signal=irq expected=%b actual=%b", $time, level, irq);
            mismatch_cnt++;
         end
      end
   endtask

   task automatic run_entry(input int unsigned k);
      logic [`NCPU_DW-1:0] rd;
      logic [`NCPU_DW-1:0] m;
      m = tbl_mask[k];
      case (tbl_op[k])
         OP_WRITE: msr_access(1'b1, tbl_addr[k], tbl_data[k], rd);
         OP_READ: begin
            msr_access(1'b0, tbl_addr[k], '0, rd);
            if ((rd & m) !== (tbl_exp[k] & m)) begin
               $display("MISMATCH time=%0t signal=msr_rdata(%s) expected=%h actual=%h",
                        $time, reg_name(tbl_addr[k]), tbl_exp[k] & m, rd & m);
               mismatch_cnt++;
            end
         end
         OP_READ_MIN: begin
            msr_access(1'b0, tbl_addr[k], '0, rd);
            // Lower bound only because the counter keeps running
            if ($isunknown(rd) || ((rd & m) < tbl_exp[k])) begin
               $display("MISMATCH time=%0t signal=msr_rdata(%s) expected>=%h actual=%h",
                        $time, reg_name(tbl_addr[k]), tbl_exp[k], rd & m);
               mismatch_cnt++;
            end
         end
         OP_WAIT_IRQ: wait_irq(tbl_exp[k][0], tbl_data[k]);
         OP_HOLD_IRQ: hold_irq(tbl_exp[k][0], tbl_data[k]);
         OP_SET_EXT: begin
            @(negedge clk);
            ext_irq = tbl_data[k][`NCPU_EXT_IRQ_NUM-1:0];
         end
         default: begin
            $display("Unknown table operation in entry %0d", k);
            proto_cnt++;
         end
      endcase
   endtask

   initial begin
      rst_n = 1'b0;
      msr_req = 1'b0;
      msr_we = 1'b0;
      msr_addr = MSR_TSR;
      msr_wdata = '0;
      ext_irq = '0;
      void'($urandom(10847));
      build_table();
      if (tbl_cnt != TBL_LEN) begin
         $display("Table holds %0d entries where %0d were expected", tbl_cnt, TBL_LEN);
         proto_cnt++;
      end
      // Reset held for 10 cycles
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      for (int unsigned k = 0; k < TBL_LEN; k++) begin
         run_entry(k);
      end
      $display("Summary: %0d mismatches, %0d handshake faults, %0d timeouts",
               mismatch_cnt, proto_cnt, timeout_cnt);
      if (mismatch_cnt + proto_cnt + timeout_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog sized from the table
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired at %0t before the table finished", $time);
      $display("Summary: %0d mismatches, %0d handshake faults, %0d timeouts",
               mismatch_cnt, proto_cnt, timeout_cnt);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* compile.f */
+incdir+include
hw/tsc_pkg.sv
hw/msr_bus_slave.sv
hw/tsc_timer.sv
hw/epu_irq_ctrl.sv
hw/epu_tsc_top.sv
testbench/tb_epu_tsc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the EPU timestamp testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
   --top-module tb_epu_tsc -f compile.f

sim_out=$(./obj_dir/Vtb_epu_tsc)
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL CHECKS PASSED"; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
